/* Makefile */
TOP = tb_soc_bus

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the regression into sim.log"
	@echo "  clean  remove obj_dir and sim.log"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert -j 0 --top-module $(TOP) -f soc_bus.f
	@./obj_dir/V$(TOP) > sim.log 2>&1; status=$$?; cat sim.log; \
	if [ $$status -ne 0 ] || grep -q "Regression failed" sim.log; then \
		echo "test: failure found, see sim.log"; exit 1; \
	fi

clean:
	rm -rf obj_dir sim.log

/* design/addr_decode.sv */
`timescale 1ns/1ps

module addr_decode import bus_pkg::*, map_pkg::*; #(
	parameter int RAM_WORDS = 256
) (
	input addr_u i_address,
	output target_sel_t o_select
);

	localparam logic [27:0] ROM_BYTES = 28'(ROM_WORDS * 4);
	localparam logic [27:0] RAM_BYTES = 28'(RAM_WORDS * 4);

	always_comb begin
		o_select = '0;
		case (i_address.near.region)
			REGION_ROM: begin
				if (i_address.near.offset < ROM_BYTES)
					o_select.rom = 1'b1;
				else
					o_select.fault = 1'b1;
			end
			REGION_RAM: begin
				if (i_address.near.offset < RAM_BYTES)
					o_select.ram = 1'b1;
				else
					o_select.fault = 1'b1;
			end
			REGION_FAR: begin
				// second decode, far view by device nibble
				if (i_address.far.device == DEVICE_SYSREG)
					o_select.sysreg = 1'b1;
				else
					o_select.fault = 1'b1;
			end
			default: o_select.fault = 1'b1;
		endcase
	end

endmodule

/* design/boot_rom.sv */
`timescale 1ns/1ps

module boot_rom import bus_pkg::*, map_pkg::*; (
	input logic i_clock,
	input logic i_reset,
	input bus_req_t i_bus,
	input logic i_select,
	output bus_rsp_t o_rsp
);

	localparam int INDEX_BITS = $clog2(ROM_WORDS);

	logic [31:0] rom [ROM_WORDS];
	logic [INDEX_BITS-1:0] index;
	logic rsp_ready;
	logic [31:0] rsp_rdata;

	initial begin
		$readmemh(ROM_IMAGE, rom);
	end

	assign index = i_bus.address.near.offset[INDEX_BITS+1:2];

	// writes get acked too, contents never change
	always_ff @(posedge i_clock) begin
		if (i_reset)
			rsp_ready <= 1'b0;
		else
			rsp_ready <= i_select && i_bus.request && !rsp_ready;
	end

	always_ff @(posedge i_clock) begin
		rsp_rdata <= rom[index];
	end

	assign o_rsp = '{ready: rsp_ready, rdata: rsp_rdata};

endmodule

/* design/bus_arbiter.sv */
`timescale 1ns/1ps

module bus_arbiter import bus_pkg::*; (
	input logic i_clock,
	input logic i_reset,

	input fetch_req_t i_fetch,
	input bus_req_t i_data,
	output bus_rsp_t o_fetch,
	output bus_rsp_t o_data,

	output bus_req_t o_bus,
	input bus_rsp_t i_bus,
	output master_t o_owner
);

	typedef enum logic {
		ST_IDLE,
		ST_BUSY
	} state_t;

	state_t state;
	master_t owner;
	bus_req_t granted;
	logic bus_done;

	assign bus_done = (state == ST_BUSY) && i_bus.ready;

	always_ff @(posedge i_clock) begin
		if (i_reset) begin
			state <= ST_IDLE;
			owner <= MASTER_FETCH;
		end else begin
			case (state)
				ST_IDLE: begin
					// data port has priority, fetch just waits
					if (i_data.request) begin
						granted <= i_data;
						owner <= MASTER_DATA;
						state <= ST_BUSY;
					end else if (i_fetch.request) begin
						granted <= '{request: 1'b1, rw: 1'b0,
							address: i_fetch.address, wdata: 32'h0};
						owner <= MASTER_FETCH;
						state <= ST_BUSY;
					end
				end
				ST_BUSY: begin
					// one idle cycle after each transfer, the owner drops its request
					if (i_bus.ready)
						state <= ST_IDLE;
				end
				default: state <= ST_IDLE;
			endcase
		end
	end

	assign o_bus = '{request: state == ST_BUSY, rw: granted.rw,
		address: granted.address, wdata: granted.wdata};
	assign o_owner = owner;

	// response goes back to whoever holds the grant
	assign o_fetch = '{ready: bus_done && (owner == MASTER_FETCH), rdata: i_bus.rdata};
	assign o_data = '{ready: bus_done && (owner == MASTER_DATA), rdata: i_bus.rdata};

endmodule

/* design/bus_pkg.sv */
package bus_pkg;

	// near view: region nibble over a flat offset
	typedef struct packed {
		logic [3:0] region;
		logic [27:0] offset;
	} near_addr_t;

	// far view: region, device, then offset within the device
	typedef struct packed {
		logic [3:0] region;
		logic [3:0] device;
		logic [23:0] offset;
	} far_addr_t;

	typedef union packed {
		near_addr_t near;
		far_addr_t far;
	} addr_u;

	typedef struct packed {
		logic request;
		addr_u address;
	} fetch_req_t;

	typedef struct packed {
		logic request;
		logic rw;
		addr_u address;
		logic [31:0] wdata;
	} bus_req_t;

	typedef struct packed {
		logic ready;
		logic [31:0] rdata;
	} bus_rsp_t;

	typedef enum logic {
		MASTER_FETCH = 1'b0,
		MASTER_DATA = 1'b1
	} master_t;

	// one-hot, exactly one bit set by the decoder
	typedef struct packed {
		logic rom;
		logic ram;
		logic sysreg;
		logic fault;
	} target_sel_t;

endpackage

/* design/map_pkg.sv */
package map_pkg;

	// ==================================================
	// regions, top nibble of the address
	localparam logic [3:0] REGION_ROM = 4'h0;
	localparam logic [3:0] REGION_RAM = 4'h2;
	localparam logic [3:0] REGION_FAR = 4'h5;

	// far devices, bits 27:24
	localparam logic [3:0] DEVICE_SYSREG = 4'h9;

	// ==================================================
	// boot rom
	localparam int ROM_WORDS = 16;
	localparam string ROM_IMAGE = "rom_image.hex";

	// system register word offsets
	localparam logic [1:0] SYSREG_ID = 2'd0;
	localparam logic [1:0] SYSREG_LEDS = 2'd1;
	localparam logic [1:0] SYSREG_SCRATCH = 2'd2;

endpackage

/* design/ram_latency.sv */
`timescale 1ns/1ps

module ram_latency import bus_pkg::*; #(
	parameter int RAM_WORDS = 256,
	parameter int RAM_LATENCY = 3
) (
	input logic i_clock,
	input logic i_reset,
	input bus_req_t i_bus,
	input logic i_select,
	output bus_rsp_t o_rsp
);

	localparam int INDEX_BITS = $clog2(RAM_WORDS);

	logic [31:0] mem [RAM_WORDS];
	logic [INDEX_BITS-1:0] index;
	logic [RAM_LATENCY-1:0] valid_pipe;
	logic accept;
	logic [31:0] rdata_q;

	assign index = i_bus.address.near.offset[INDEX_BITS+1:2];

	// only one access in flight at a time
	assign accept = i_select && i_bus.request && (valid_pipe == '0);

	always_ff @(posedge i_clock) begin
		if (i_reset)
			valid_pipe <= '0;
		else
			valid_pipe <= (valid_pipe << 1) | RAM_LATENCY'(accept);
	end

	// store and sample on acceptance
	always_ff @(posedge i_clock) begin
		if (accept) begin
			if (i_bus.rw)
				mem[index] <= i_bus.wdata;
			rdata_q <= mem[index];
		end
	end

	assign o_rsp = '{ready: valid_pipe[RAM_LATENCY-1], rdata: rdata_q};

endmodule

/* design/response_mux.sv */
`timescale 1ns/1ps

module response_mux import bus_pkg::*; (
	input logic i_clock,
	input logic i_reset,
	input bus_req_t i_bus,
	input target_sel_t i_select,
	input master_t i_owner,
	input bus_rsp_t i_rom,
	input bus_rsp_t i_ram,
	input bus_rsp_t i_sysreg,
	output bus_rsp_t o_rsp,
	output logic o_fault,
	output logic [31:0] o_fault_address,
	output master_t o_fault_master
);

	logic fault_accept;
	logic fault_ready;
	logic fault_seen;

	assign fault_accept = i_select.fault && i_bus.request && !fault_ready;

	always_ff @(posedge i_clock) begin
		if (i_reset) begin
			fault_ready <= 1'b0;
			fault_seen <= 1'b0;
		end else begin
			fault_ready <= fault_accept;
			if (fault_accept)
				fault_seen <= 1'b1;
		end
	end

	// sticky, only the first fault after reset is kept
	always_ff @(posedge i_clock) begin
		if (fault_accept && !fault_seen) begin
			o_fault_address <= i_bus.address;
			o_fault_master <= i_owner;
		end
	end

	always_comb begin
		if (i_select.rom)
			o_rsp = i_rom;
		else if (i_select.ram)
			o_rsp = i_ram;
		else if (i_select.sysreg)
			o_rsp = i_sysreg;
		else
			o_rsp = '{ready: fault_ready, rdata: 32'h0};
	end

	assign o_fault = fault_seen;

endmodule

/* design/soc_bus.sv */
`timescale 1ns/1ps

module soc_bus import bus_pkg::*; #(
	parameter int RAM_WORDS = 256,
	parameter int RAM_LATENCY = 3,
	parameter logic [31:0] DEVICE_ID = 32'd1
) (
	input logic i_clock,
	input logic i_reset,

	input fetch_req_t i_fetch,
	output bus_rsp_t o_fetch,

	input bus_req_t i_data,
	output bus_rsp_t o_data,

	output logic [9:0] o_leds,

	output logic o_fault,
	output logic [31:0] o_fault_address,
	output master_t o_fault_master
);

	bus_req_t bus_req;
	bus_rsp_t bus_rsp;
	master_t bus_owner;
	target_sel_t bus_select;

	bus_rsp_t rom_rsp;
	bus_rsp_t ram_rsp;
	bus_rsp_t sysreg_rsp;

	// ==================================================
	// arbitration
	bus_arbiter arbiter (
		.i_clock(i_clock),
		.i_reset(i_reset),
		.i_fetch(i_fetch),
		.i_data(i_data),
		.o_fetch(o_fetch),
		.o_data(o_data),
		.o_bus(bus_req),
		.i_bus(bus_rsp),
		.o_owner(bus_owner)
	);

	// ==================================================
	// decode
	addr_decode #(
		.RAM_WORDS(RAM_WORDS)
	) decode (
		.i_address(bus_req.address),
		.o_select(bus_select)
	);

	// ==================================================
	// targets
	boot_rom rom (
		.i_clock(i_clock),
		.i_reset(i_reset),
		.i_bus(bus_req),
		.i_select(bus_select.rom),
		.o_rsp(rom_rsp)
	);

	ram_latency #(
		.RAM_WORDS(RAM_WORDS),
		.RAM_LATENCY(RAM_LATENCY)
	) ram (
		.i_clock(i_clock),
		.i_reset(i_reset),
		.i_bus(bus_req),
		.i_select(bus_select.ram),
		.o_rsp(ram_rsp)
	);

	sys_registers #(
		.DEVICE_ID(DEVICE_ID)
	) sysreg (
		.i_clock(i_clock),
		.i_reset(i_reset),
		.i_bus(bus_req),
		.i_select(bus_select.sysreg),
		.o_rsp(sysreg_rsp),
		.o_leds(o_leds)
	);

	// ==================================================
	// response and fault capture
	response_mux rsp_mux (
		.i_clock(i_clock),
		.i_reset(i_reset),
		.i_bus(bus_req),
		.i_select(bus_select),
		.i_owner(bus_owner),
		.i_rom(rom_rsp),
		.i_ram(ram_rsp),
		.i_sysreg(sysreg_rsp),
		.o_rsp(bus_rsp),
		.o_fault(o_fault),
		.o_fault_address(o_fault_address),
		.o_fault_master(o_fault_master)
	);

endmodule

/* design/sys_registers.sv */
`timescale 1ns/1ps

module sys_registers import bus_pkg::*, map_pkg::*; #(
	parameter logic [31:0] DEVICE_ID = 32'd1
) (
	input logic i_clock,
	input logic i_reset,
	input bus_req_t i_bus,
	input logic i_select,
	output bus_rsp_t o_rsp,
	output logic [9:0] o_leds
);

	logic [1:0] offset;
	logic accept;
	logic rsp_ready;
	logic [31:0] rsp_rdata;
	logic [31:0] read_word;
	logic [9:0] leds;
	logic [31:0] scratch;

	assign offset = i_bus.address.far.offset[3:2];
	assign accept = i_select && i_bus.request && !rsp_ready;

	always_comb begin
		case (offset)
			SYSREG_ID: read_word = DEVICE_ID;
			SYSREG_LEDS: read_word = {22'h0, leds};
			SYSREG_SCRATCH: read_word = scratch;
			default: read_word = 32'h0;
		endcase
	end

	always_ff @(posedge i_clock) begin
		if (i_reset) begin
			rsp_ready <= 1'b0;
			leds <= 10'h0;
			scratch <= 32'h0;
		end else begin
			rsp_ready <= accept;
			// id is read only
			if (accept && i_bus.rw) begin
				if (offset == SYSREG_LEDS)
					leds <= i_bus.wdata[9:0];
				if (offset == SYSREG_SCRATCH)
					scratch <= i_bus.wdata;
			end
		end
	end

	always_ff @(posedge i_clock) begin
		if (accept)
			rsp_rdata <= read_word;
	end

	assign o_rsp = '{ready: rsp_ready, rdata: rsp_rdata};
	assign o_leds = leds;

endmodule

/* rom_image.hex */
// boot rom image, one 32-bit word per line, word 0 first
3c1d0000
27bd0400
8fa40000
00000000
24020001
ac820004
1440fffe
00000000
0bad0c0d
5a5aa5a5
12345678
9abcdef0
deadbeef
cafef00d
0f1e2d3c
fffffffe

/* soc_bus.f */
design/bus_pkg.sv
design/map_pkg.sv
design/bus_arbiter.sv
design/addr_decode.sv
design/boot_rom.sv
design/ram_latency.sv
design/sys_registers.sv
design/response_mux.sv
design/soc_bus.sv
testbench/soc_bus_asserts.sv
testbench/tb_soc_bus.sv

/* testbench/soc_bus_asserts.sv */
`timescale 1ns/1ps

module soc_bus_asserts import bus_pkg::*; (
	input logic i_clock,
	input logic i_reset,
	input bus_rsp_t i_fetch_rsp,
	input bus_rsp_t i_data_rsp,
	input bus_req_t i_bus_req,
	input bus_rsp_t i_bus_rsp,
	input target_sel_t i_select,
	input logic i_fault
);

	logic fault_select_seen;

	always_ff @(posedge i_clock) begin
		if (i_reset)
			fault_select_seen <= 1'b0;
		else if (i_select.fault && i_bus_req.request)
			fault_select_seen <= 1'b1;
	end

	// ==================================================
	// bus protocol
	single_ready: assert property (@(posedge i_clock) disable iff (i_reset)
		!(i_fetch_rsp.ready && i_data_rsp.ready))
		else $error("fetch and data ready high together");

	request_held: assert property (@(posedge i_clock) disable iff (i_reset)
		(i_bus_req.request && !i_bus_rsp.ready) |=> (i_bus_req.request && $stable(i_bus_req)))
		else $error("bus request changed before ready");

	ready_with_request: assert property (@(posedge i_clock) disable iff (i_reset)
		i_bus_rsp.ready |-> i_bus_req.request)
		else $error("bus ready without an active request");

	fault_after_select: assert property (@(posedge i_clock) disable iff (i_reset)
		i_fault |-> fault_select_seen)
		else $error("fault flag raised before any fault select");

endmodule

bind soc_bus soc_bus_asserts asserts (
	.i_clock(i_clock),
	.i_reset(i_reset),
	.i_fetch_rsp(o_fetch),
	.i_data_rsp(o_data),
	.i_bus_req(bus_req),
	.i_bus_rsp(bus_rsp),
	.i_select(bus_select),
	.i_fault(o_fault)
);

/* testbench/tb_soc_bus.sv */
`timescale 1ns/1ps

module tb_clock_gen #(
	parameter int PERIOD = 40
) (
	output logic o_clock
);

	initial o_clock = 1'b0;

	always #(PERIOD / 2) o_clock = ~o_clock;

endmodule

module tb_soc_bus import bus_pkg::*; ();

	localparam int RAM_WORDS = 256;
	localparam int RAM_LATENCY = 3;
	localparam logic [31:0] DEVICE_ID = 32'h0000_5a17;
	localparam int WAIT_LIMIT = 50;

	// one row of the stimulus table
	// the expected value only matters for reads
	typedef struct packed {
		master_t master;
		logic rw;
		logic [31:0] address;
		logic [31:0] wdata;
		logic [31:0] expected;
	} entry_t;

	logic clock;
	logic reset;
	fetch_req_t fetch_req;
	bus_rsp_t fetch_rsp;
	bus_req_t data_req;
	bus_rsp_t data_rsp;
	logic [9:0] leds;
	logic fault;
	logic [31:0] fault_address;
	master_t fault_master;

	entry_t entries[$];
	string entry_names[$];
	int phase_split;
	logic [31:0] lcg_state;
	logic [31:0] rom_words [16];
	logic [31:0] ram_values [4];
	logic [31:0] scratch_value;
	logic [31:0] ram_addresses [4] = '{32'h2000_0010, 32'h2000_0124, 32'h2000_03fc,
		32'h2000_0200};
	int read_order [4] = '{2, 0, 3, 1};

	tb_clock_gen #(
		.PERIOD(40)
	) clock_gen (
		.o_clock(clock)
	);

	soc_bus #(
		.RAM_WORDS(RAM_WORDS),
		.RAM_LATENCY(RAM_LATENCY),
		.DEVICE_ID(DEVICE_ID)
	) UUT (
		.i_clock(clock),
		.i_reset(reset),
		.i_fetch(fetch_req),
		.o_fetch(fetch_rsp),
		.i_data(data_req),
		.o_data(data_rsp),
		.o_leds(leds),
		.o_fault(fault),
		.o_fault_address(fault_address),
		.o_fault_master(fault_master)
	);

	// ==================================================
	// helpers
	function automatic logic [31:0] next_random();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return lcg_state;
	endfunction

	task automatic abort_run();
		$display("Regression failed");
		$fatal(1, "stopping at the first error");
	endtask

	task automatic check_value(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		if (actual !== expected) begin
			$display("** Error %s: expected %08h, actual %08h", name, expected, actual);
			abort_run();
		end
	endtask

	task automatic add_entry(input string name, input master_t master, input logic rw,
		input logic [31:0] address, input logic [31:0] wdata, input logic [31:0] expected);
		entries.push_back('{master: master, rw: rw, address: address, wdata: wdata,
			expected: expected});
		entry_names.push_back(name);
	endtask

	task automatic apply_reset();
		repeat (2) @(posedge clock);
		reset <= 1'b0;
	endtask

	// ==================================================
	// bus transfers
	task automatic run_transfer(input string name, input master_t master, input logic rw,
		input logic [31:0] address, input logic [31:0] wdata, output logic [31:0] rdata);
		int cycles;
		logic done;
		cycles = 0;
		done = 1'b0;
		rdata = 32'h0;
		@(posedge clock);
		if (master == MASTER_DATA)
			data_req <= '{request: 1'b1, rw: rw, address: address, wdata: wdata};
		else
			fetch_req <= '{request: 1'b1, address: address};
		// outputs are looked at on the falling edge
		while (!done && cycles < WAIT_LIMIT) begin
			@(negedge clock);
			cycles++;
			if (master == MASTER_DATA && data_rsp.ready) begin
				done = 1'b1;
				rdata = data_rsp.rdata;
			end
			if (master == MASTER_FETCH && fetch_rsp.ready) begin
				done = 1'b1;
				rdata = fetch_rsp.rdata;
			end
		end
		@(posedge clock);
		data_req.request <= 1'b0;
		fetch_req.request <= 1'b0;
		if (!done) begin
			$display("no ready seen for %s within %0d cycles", name, WAIT_LIMIT);
			abort_run();
		end
	endtask

	task automatic apply_entries(input int first, input int last);
		entry_t entry;
		logic [31:0] rdata;
		for (int i = first; i < last; i++) begin
			entry = entries[i];
			run_transfer(entry_names[i], entry.master, entry.rw, entry.address,
				entry.wdata, rdata);
			if (!entry.rw)
				check_value(entry_names[i], entry.expected, rdata);
		end
	endtask

	// both ports raise request on the same edge
	task automatic run_both(input logic [31:0] fetch_address, input logic [31:0] data_address,
		output logic [31:0] fetch_rdata, output logic [31:0] data_rdata,
		output logic data_first);
		int cycles;
		logic fetch_done;
		logic data_done;
		cycles = 0;
		fetch_done = 1'b0;
		data_done = 1'b0;
		data_first = 1'b0;
		fetch_rdata = 32'h0;
		data_rdata = 32'h0;
		@(posedge clock);
		fetch_req <= '{request: 1'b1, address: fetch_address};
		data_req <= '{request: 1'b1, rw: 1'b0, address: data_address, wdata: 32'h0};
		while (!(fetch_done && data_done) && cycles < WAIT_LIMIT) begin
			@(negedge clock);
			cycles++;
			if (data_rsp.ready && !data_done) begin
				data_done = 1'b1;
				data_rdata = data_rsp.rdata;
				data_first = !fetch_done;
			end
			if (fetch_rsp.ready && !fetch_done) begin
				fetch_done = 1'b1;
				fetch_rdata = fetch_rsp.rdata;
			end
			@(posedge clock);
			if (data_done)
				data_req.request <= 1'b0;
			if (fetch_done)
				fetch_req.request <= 1'b0;
		end
		if (!(fetch_done && data_done)) begin
			$display("simultaneous requests did not both complete within %0d cycles",
				WAIT_LIMIT);
			abort_run();
		end
	endtask

	// ==================================================
	// table and sequence
	task automatic build_table();
		add_entry("rom word 0", MASTER_FETCH, 1'b0, 32'h0000_0000, 32'h0, rom_words[0]);
		add_entry("rom word 3", MASTER_FETCH, 1'b0, 32'h0000_000c, 32'h0, rom_words[3]);
		add_entry("rom word 7", MASTER_FETCH, 1'b0, 32'h0000_001c, 32'h0, rom_words[7]);
		add_entry("rom word 15", MASTER_FETCH, 1'b0, 32'h0000_003c, 32'h0, rom_words[15]);
		add_entry("rom write", MASTER_DATA, 1'b1, 32'h0000_0008, 32'hffff_0000, 32'h0);
		add_entry("rom after write", MASTER_DATA, 1'b0, 32'h0000_0008, 32'h0, rom_words[2]);
		for (int k = 0; k < 4; k++)
			add_entry($sformatf("ram write %0d", k), MASTER_DATA, 1'b1, ram_addresses[k],
				ram_values[k], 32'h0);
		for (int k = 0; k < 4; k++)
			add_entry($sformatf("ram read %0d", read_order[k]), MASTER_DATA, 1'b0,
				ram_addresses[read_order[k]], 32'h0, ram_values[read_order[k]]);
		add_entry("sysreg id", MASTER_DATA, 1'b0, 32'h5900_0000, 32'h0, DEVICE_ID);
		add_entry("leds write", MASTER_DATA, 1'b1, 32'h5900_0004, 32'hffff_f2a5, 32'h0);
		add_entry("leds read", MASTER_DATA, 1'b0, 32'h5900_0004, 32'h0, 32'h0000_02a5);
		add_entry("scratch write", MASTER_DATA, 1'b1, 32'h5900_0008, scratch_value, 32'h0);
		add_entry("scratch read", MASTER_DATA, 1'b0, 32'h5900_0008, 32'h0, scratch_value);
		add_entry("sysreg unused", MASTER_DATA, 1'b0, 32'h5900_000c, 32'h0, 32'h0);
		add_entry("first fault", MASTER_FETCH, 1'b0, 32'h3000_0000, 32'h0, 32'h0);
		phase_split = entries.size();
		add_entry("second fault", MASTER_DATA, 1'b1, 32'h5100_0000, 32'h1, 32'h0);
	endtask

	task automatic check_fault_record(input string stage);
		@(negedge clock);
		check_value({stage, " flag"}, 32'h1, {31'h0, fault});
		check_value({stage, " address"}, 32'h3000_0000, fault_address);
		check_value({stage, " master"}, 32'(MASTER_FETCH), 32'(fault_master));
	endtask

	task automatic check_after_reset();
		@(negedge clock);
		check_value("reset fetch ready", 32'h0, {31'h0, fetch_rsp.ready});
		check_value("reset data ready", 32'h0, {31'h0, data_rsp.ready});
		check_value("reset leds", 32'h0, {22'h0, leds});
		check_value("reset fault", 32'h0, {31'h0, fault});
	endtask

	task automatic check_parallel();
		logic [31:0] fetch_rdata;
		logic [31:0] data_rdata;
		logic data_first;
		run_both(32'h0000_0014, ram_addresses[1], fetch_rdata, data_rdata, data_first);
		check_value("parallel fetch", rom_words[5], fetch_rdata);
		check_value("parallel data", ram_values[1], data_rdata);
		check_value("parallel data first", 32'h1, {31'h0, data_first});
	endtask

	initial begin
		reset = 1'b1;
		fetch_req = '0;
		data_req = '0;
		lcg_state = 32'h579632df;
		$readmemh("rom_image.hex", rom_words);
		for (int k = 0; k < 4; k++)
			ram_values[k] = next_random();
		scratch_value = next_random();
		build_table();
		apply_reset();
		check_after_reset();
		apply_entries(0, phase_split);
		check_fault_record("first fault");
		check_value("leds output", 32'h0000_02a5, {22'h0, leds});
		// a second fault must leave the record alone
		apply_entries(phase_split, entries.size());
		check_fault_record("second fault");
		check_parallel();
		$display("Regression passed");
		$finish;
	end

endmodule
